// ==== logic/evt_link_pkg.sv ====
package evt_link_pkg;

    // Lane and word types
    typedef logic [7:0]  evt_code_t;
    typedef logic [7:0]  link_byte_t;
    typedef logic [15:0] link_word_t;  // [15:8] event lane, [7:0] data lane
    typedef logic [1:0]  k_flags_t;    // [1] event lane, [0] data lane

    // Frame geometry
    typedef logic [4:0]  seg_addr_t;   // Byte index into segment buffer
    typedef logic [5:0]  frame_idx_t;  // Word index, two words per buffer byte

    // 8b10b control symbols
    localparam link_byte_t K28_5     = 8'hBC;  // Comma
    localparam link_byte_t SEG_START = 8'h5C;
    localparam link_byte_t SEG_STOP  = 8'h3C;

    localparam int SEG_BYTES     = 32;
    localparam int COMMA_SPACING = 4;  // One comma every fourth word

endpackage

// ==== logic/evt_regmap_pkg.sv ====
package evt_regmap_pkg;

    typedef logic [3:0]  reg_addr_t;
    typedef logic [15:0] reg_data_t;
    typedef logic [15:0] presc_t;

    // Register map
    localparam reg_addr_t REG_CTRL     = 4'd0;
    localparam reg_addr_t REG_PRESC    = 4'd1;
    localparam reg_addr_t REG_SEG_ADDR = 4'd2;
    localparam reg_addr_t REG_SEG_DATA = 4'd3;  // Auto-incrementing byte port
    localparam reg_addr_t REG_EVT_DATA = 4'd4;  // Read pops the event FIFO
    localparam reg_addr_t REG_STATUS   = 4'd5;

    // CTRL bits
    localparam int CTRL_LINK_EN = 0;
    localparam int CTRL_SRC_EN  = 1;
    localparam int CTRL_CLEAR   = 2;  // Self-clearing

    // STATUS and EVT_DATA fields
    localparam int STAT_EMPTY     = 0;
    localparam int STAT_FULL      = 1;
    localparam int STAT_COUNT_LSB = 8;
    localparam int EVT_VALID      = 8;

endpackage

// ==== logic/evt_ifs.sv ====
// Host side of the event FIFO
interface evt_fifo_if
    import evt_link_pkg::*;
#(
    parameter int EVT_FIFO_DEPTH = 16
) ();
    localparam int CNT_W = $clog2(EVT_FIFO_DEPTH) + 1;

    logic             pop;
    logic             clear;
    evt_code_t        code;   // Head entry
    logic             empty;
    logic             full;
    logic [CNT_W-1:0] count;

    modport host (output pop, output clear, input code, input empty, input full, input count);
    modport fifo (input pop, input clear, output code, output empty, output full, output count);
endinterface

// Segment buffer write port and link enable
interface seg_buf_if
    import evt_link_pkg::*;
();
    logic       wr;
    seg_addr_t  addr;
    link_byte_t data;
    logic       link_en;

    modport regs (output wr, output addr, output data, output link_en);
    modport gen  (input wr, input addr, input data, input link_en);
endinterface

// ==== logic/evt_regs.sv ====
module evt_regs
    import evt_link_pkg::*;
    import evt_regmap_pkg::*;
#(
    parameter int EVT_FIFO_DEPTH = 16
) (
    input  logic            clk,
    input  logic            reset_i,
    input  reg_addr_t       reg_addr_i,
    input  logic            reg_wr_i,
    input  logic            reg_rd_i,
    input  reg_data_t       reg_wdata_i,
    output reg_data_t       reg_rdata_o,
    evt_fifo_if.host        fifo,
    seg_buf_if.regs         seg,
    output presc_t          presc_o,
    output logic            src_en_o,
    output logic            clear_o
);
    localparam int CNT_W = $clog2(EVT_FIFO_DEPTH) + 1;

    logic      link_en;
    logic      src_en;
    presc_t    presc;
    seg_addr_t seg_addr;
    reg_data_t rd_val;

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            link_en  <= 1'b0;
            src_en   <= 1'b0;
            presc    <= '0;
            seg_addr <= '0;
        end
        else if (reg_wr_i)
        begin
            case (reg_addr_i)
                REG_CTRL:
                begin
                    link_en <= reg_wdata_i[CTRL_LINK_EN];
                    src_en  <= reg_wdata_i[CTRL_SRC_EN];
                end
                REG_PRESC:    presc    <= reg_wdata_i;
                REG_SEG_ADDR: seg_addr <= reg_wdata_i[$bits(seg_addr_t)-1:0];
                REG_SEG_DATA: seg_addr <= seg_addr + 1'b1;  // Wraps at 32
                default:      ;
            endcase
        end
    end

    // Clear acts at the write edge itself
    assign clear_o = reg_wr_i && (reg_addr_i == REG_CTRL) && reg_wdata_i[CTRL_CLEAR];

    assign seg.wr      = reg_wr_i && (reg_addr_i == REG_SEG_DATA);
    assign seg.addr    = seg_addr;
    assign seg.data    = reg_wdata_i[$bits(link_byte_t)-1:0];
    assign seg.link_en = link_en;

    assign fifo.clear = clear_o;
    assign fifo.pop   = reg_rd_i && (reg_addr_i == REG_EVT_DATA);  // FIFO ignores pop when empty

    assign presc_o  = presc;
    assign src_en_o = src_en;

    always_comb
    begin
        rd_val = '0;
        case (reg_addr_i)
            REG_CTRL:
            begin
                rd_val[CTRL_LINK_EN] = link_en;
                rd_val[CTRL_SRC_EN]  = src_en;
            end
            REG_PRESC:    rd_val = presc;
            REG_SEG_ADDR: rd_val[$bits(seg_addr_t)-1:0] = seg_addr;
            REG_EVT_DATA:
            begin
                if (!fifo.empty)
                begin
                    rd_val[$bits(evt_code_t)-1:0] = fifo.code;
                    rd_val[EVT_VALID]             = 1'b1;
                end
            end
            REG_STATUS:
            begin
                rd_val[STAT_EMPTY]                = fifo.empty;
                rd_val[STAT_FULL]                 = fifo.full;
                rd_val[STAT_COUNT_LSB +: CNT_W]   = fifo.count;
            end
            default:      rd_val = '0;  // Unmapped
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
            reg_rdata_o <= '0;
        else if (reg_rd_i)
            reg_rdata_o <= rd_val;
    end

endmodule

// ==== logic/evt_source.sv ====
module evt_source
    import evt_link_pkg::*;
    import evt_regmap_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      clear_i,
    input  logic      src_en_i,
    input  presc_t    presc_i,
    input  logic      full_i,
    output logic      push_o,
    output evt_code_t code_o
);
    presc_t    cnt;
    evt_code_t code;
    logic      run;

    assign run = src_en_i && !full_i;  // Frozen while FIFO is full

    always_ff @(posedge clk)
    begin
        if (reset_i || clear_i)
        begin
            cnt  <= '0;
            code <= '0;
        end
        else if (run)
        begin
            if (cnt == presc_i)
            begin
                cnt  <= '0;
                code <= code + 1'b1;  // Next code after each push
            end
            else
                cnt <= cnt + 1'b1;
        end
    end

    assign push_o = run && (cnt == presc_i);
    assign code_o = code;

endmodule

// ==== logic/evt_fifo.sv ====
module evt_fifo
    import evt_link_pkg::*;
#(
    parameter int EVT_FIFO_DEPTH = 16
) (
    input  logic      clk,
    input  logic      reset_i,
    input  logic      push_i,
    input  evt_code_t code_i,
    output logic      full_o,
    evt_fifo_if.fifo  fifo
);
    localparam int AW    = $clog2(EVT_FIFO_DEPTH);
    localparam int CNT_W = AW + 1;

    evt_code_t        mem [EVT_FIFO_DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push_ok;
    logic             pop_ok;

    assign fifo.full  = (count == CNT_W'(EVT_FIFO_DEPTH));
    assign fifo.empty = (count == '0);
    assign fifo.count = count;
    assign fifo.code  = mem[rd_ptr];
    assign full_o     = fifo.full;

    assign push_ok = push_i && !fifo.full;
    assign pop_ok  = fifo.pop && !fifo.empty;

    always_ff @(posedge clk)
    begin
        if (push_ok)
            mem[wr_ptr] <= code_i;
    end

    always_ff @(posedge clk)
    begin
        if (reset_i || fifo.clear)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // Both or neither
            endcase
        end
    end

endmodule

// ==== logic/frame_gen.sv ====
module frame_gen
    import evt_link_pkg::*;
(
    input  logic       clk,
    input  logic       reset_i,
    seg_buf_if.gen     seg,
    output link_word_t tx_data_o,
    output k_flags_t   tx_is_k_o
);
    link_byte_t seg_mem [SEG_BYTES];  // Segment buffer
    frame_idx_t idx;
    link_byte_t evt_lane;
    link_byte_t data_lane;
    logic       comma_slot;

    always_ff @(posedge clk)
    begin
        if (seg.wr)
            seg_mem[seg.addr] <= seg.data;
    end

    // Held at word 0 until the link is enabled
    always_ff @(posedge clk)
    begin
        if (reset_i || !seg.link_en)
            idx <= '0;
        else
            idx <= idx + 1'b1;  // Wraps at 64
    end

    assign comma_slot = (idx % COMMA_SPACING) == 0;

    always_comb
    begin
        evt_lane  = '0;
        data_lane = '0;
        if (seg.link_en)
        begin
            if (comma_slot)
                evt_lane = K28_5;
            if (idx[0])
                data_lane = seg_mem[seg_addr_t'(idx >> 1)];  // One buffer byte per odd word
        end
    end

    assign tx_data_o    = {evt_lane, data_lane};
    assign tx_is_k_o[1] = (evt_lane == K28_5);
    assign tx_is_k_o[0] = (data_lane == SEG_START) || (data_lane == SEG_STOP);

endmodule

// ==== logic/evt_link_top.sv ====
module evt_link_top
    import evt_link_pkg::*;
    import evt_regmap_pkg::*;
#(
    parameter int EVT_FIFO_DEPTH = 16
) (
    input  logic       clk,
    input  logic       reset_i,
    input  reg_addr_t  reg_addr_i,
    input  logic       reg_wr_i,
    input  logic       reg_rd_i,
    input  reg_data_t  reg_wdata_i,
    output reg_data_t  reg_rdata_o,
    output link_word_t tx_data_o,
    output k_flags_t   tx_is_k_o
);
    presc_t    presc;
    logic      src_en;
    logic      clear;
    logic      push;
    evt_code_t src_code;
    logic      fifo_full;

    evt_fifo_if #(.EVT_FIFO_DEPTH(EVT_FIFO_DEPTH)) fifo_bus ();
    seg_buf_if seg_bus ();

    evt_regs #(.EVT_FIFO_DEPTH(EVT_FIFO_DEPTH)) regs0 (
        .clk, .reset_i, .reg_addr_i, .reg_wr_i, .reg_rd_i, .reg_wdata_i, .reg_rdata_o,
        .fifo(fifo_bus), .seg(seg_bus),
        .presc_o(presc), .src_en_o(src_en), .clear_o(clear)
    );

    evt_source src0 (
        .clk, .reset_i, .clear_i(clear), .src_en_i(src_en), .presc_i(presc),
        .full_i(fifo_full), .push_o(push), .code_o(src_code)
    );

    evt_fifo #(.EVT_FIFO_DEPTH(EVT_FIFO_DEPTH)) fifo0 (
        .clk, .reset_i, .push_i(push), .code_i(src_code), .full_o(fifo_full), .fifo(fifo_bus)
    );

    frame_gen gen0 (.clk, .reset_i, .seg(seg_bus), .tx_data_o, .tx_is_k_o);

endmodule

// ==== dv/tb_clkgen.sv ====
module tb_clkgen #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Released shortly after an edge, like the other stimulus
    initial
    begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        reset_o = 1'b0;
    end

endmodule

// ==== dv/evt_link_properties.sv ====
module evt_link_properties
    import evt_link_pkg::*;
#(
    parameter int EVT_FIFO_DEPTH = 16
) (
    input logic                            clk,
    input logic                            reset_i,
    input logic [$clog2(EVT_FIFO_DEPTH):0] fifo_count,
    input logic                            fifo_push,
    input logic                            fifo_full,
    input logic                            link_en,
    input link_word_t                      tx_data,
    input k_flags_t                        tx_is_k
);
    timeunit 1ns;
    timeprecision 100ps;

    count_in_range: assert property (@(posedge clk) disable iff (reset_i)
        fifo_count <= EVT_FIFO_DEPTH)
    else
        $error("FIFO count above its depth");

    no_push_when_full: assert property (@(posedge clk) disable iff (reset_i)
        fifo_push |-> !fifo_full)
    else
        $error("Event pushed into a full FIFO");

    // Frame starts on a comma
    comma_at_start: assert property (@(posedge clk) disable iff (reset_i)
        $rose(link_en) |-> (tx_data[15:8] == K28_5 && tx_is_k[1]))
    else
        $error("First word after link enable is not a comma");

    // Event lane and its flag repeat every fourth word while the link stays up
    comma_every_fourth: assert property (@(posedge clk) disable iff (reset_i)
        (link_en && $past(link_en) && $past(link_en, 2) && $past(link_en, 3)
            && $past(link_en, 4))
        |-> (tx_data[15:8] == $past(tx_data[15:8], 4)
            && tx_is_k[1] == $past(tx_is_k[1], 4)))
    else
        $error("Event lane does not repeat every fourth word");

endmodule

bind evt_fifo evt_link_properties #(.EVT_FIFO_DEPTH(EVT_FIFO_DEPTH)) fifo_props (
    .clk, .reset_i, .fifo_count(count), .fifo_push(push_i), .fifo_full(full_o),
    .link_en(1'b0), .tx_data('0), .tx_is_k('0)
);

bind frame_gen evt_link_properties gen_props (
    .clk, .reset_i, .fifo_count('0), .fifo_push(1'b0), .fifo_full(1'b0),
    .link_en(seg.link_en), .tx_data(tx_data_o), .tx_is_k(tx_is_k_o)
);

// ==== dv/evt_link_tb.sv ====
module evt_link_tb
    import evt_link_pkg::*;
    import evt_regmap_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int EVT_FIFO_DEPTH = 16;
    localparam int MAX_CYCLES     = 6000;  // Tests run well under half of this
    localparam int DRIVE_DELAY    = 10;

    localparam reg_data_t LINK_BIT  = 16'h1 << CTRL_LINK_EN;
    localparam reg_data_t SRC_BIT   = 16'h1 << CTRL_SRC_EN;
    localparam reg_data_t CLEAR_BIT = 16'h1 << CTRL_CLEAR;
    localparam reg_data_t VALID_BIT = 16'h1 << EVT_VALID;

    logic       clk;
    logic       reset_i;
    reg_addr_t  reg_addr_i;
    logic       reg_wr_i;
    logic       reg_rd_i;
    reg_data_t  reg_wdata_i;
    reg_data_t  reg_rdata_o;
    link_word_t tx_data_o;
    k_flags_t   tx_is_k_o;

    int         errors;
    int         checks;
    int         cycles = 0;
    integer     seed;
    link_byte_t seg_model [SEG_BYTES];  // Expected buffer contents

    tb_clkgen #(.HALF_PERIOD(50), .RESET_CYCLES(5)) clkgen0 (.clk, .reset_o(reset_i));

    evt_link_top #(.EVT_FIFO_DEPTH(EVT_FIFO_DEPTH)) dut0 (
        .clk, .reset_i, .reg_addr_i, .reg_wr_i, .reg_rd_i, .reg_wdata_i, .reg_rdata_o,
        .tx_data_o, .tx_is_k_o
    );

    task automatic expect_value(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic expect_true(input logic cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            errors++;
            $display("Check failed: %s at %0t", what, $time);
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        reg_addr_i  = addr;
        reg_wdata_i = data;
        reg_wr_i    = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        reg_wr_i    = 1'b0;
    endtask

    // Data is registered at the edge that ends the strobe
    task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
        reg_addr_i = addr;
        reg_rd_i   = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        reg_rd_i   = 1'b0;
        data       = reg_rdata_o;
    endtask

    task automatic verify_reg(input reg_addr_t addr, input reg_data_t exp, input string name);
        reg_data_t rd;
        read_reg(addr, rd);
        expect_value(name, rd, exp);
    endtask

    function automatic reg_data_t status_word(input int count);
        reg_data_t w;
        w                 = reg_data_t'(count) << STAT_COUNT_LSB;
        w[STAT_EMPTY]     = (count == 0);
        w[STAT_FULL]      = (count == EVT_FIFO_DEPTH);
        return w;
    endfunction

    // {k flags, event lane, data lane} for one word index
    function automatic logic [17:0] model_word(input int idx);
        link_byte_t evt;
        link_byte_t data;
        evt  = (idx % COMMA_SPACING == 0) ? K28_5 : 8'h00;
        data = (idx % 2 == 1) ? seg_model[idx / 2] : 8'h00;
        return {evt == K28_5, (data == SEG_START) || (data == SEG_STOP), evt, data};
    endfunction

    task automatic check_after_reset();
        expect_value("tx_data_o", tx_data_o, 16'h0000);
        expect_value("tx_is_k_o", tx_is_k_o, 16'h0000);
        verify_reg(REG_STATUS, status_word(0), "STATUS");
        verify_reg(REG_EVT_DATA, 16'h0000, "EVT_DATA");
    endtask

    task automatic readback_regs();
        write_reg(REG_PRESC, 16'hA5C3);
        verify_reg(REG_PRESC, 16'hA5C3, "PRESC");
        write_reg(REG_CTRL, LINK_BIT | SRC_BIT);
        verify_reg(REG_CTRL, LINK_BIT | SRC_BIT, "CTRL");
        write_reg(REG_CTRL, CLEAR_BIT);  // Enables off, source counter back to 0
        verify_reg(REG_CTRL, 16'h0000, "CTRL");
        write_reg(REG_SEG_ADDR, 16'd5);
        verify_reg(REG_SEG_ADDR, 16'd5, "SEG_ADDR");
        repeat (4) write_reg(REG_SEG_DATA, 16'h0000);
        verify_reg(REG_SEG_ADDR, 16'd9, "SEG_ADDR");
        write_reg(REG_SEG_ADDR, 16'd30);
        repeat (4) write_reg(REG_SEG_DATA, 16'h0000);
        verify_reg(REG_SEG_ADDR, 16'd2, "SEG_ADDR");  // Wrapped
        verify_reg(4'hF, 16'h0000, "unmapped register");
    endtask

    task automatic frame_pattern();
        logic [17:0] exp;
        write_reg(REG_SEG_ADDR, 16'h0000);
        for (int i = 0; i < SEG_BYTES; i++)
        begin
            if (i == 0)
                seg_model[i] = SEG_START;
            else if (i == 18)
                seg_model[i] = SEG_STOP;
            else
                seg_model[i] = link_byte_t'($random(seed));
            write_reg(REG_SEG_DATA, {8'h00, seg_model[i]});
        end
        write_reg(REG_CTRL, LINK_BIT);
        for (int n = 0; n < 128; n++)
        begin
            exp = model_word(n % 64);
            expect_value("tx_data_o", tx_data_o, exp[15:0]);
            expect_value("tx_is_k_o", tx_is_k_o, exp[17:16]);
            @(posedge clk);
            #DRIVE_DELAY;
        end
        write_reg(REG_CTRL, 16'h0000);
        expect_value("tx_data_o", tx_data_o, 16'h0000);
        expect_value("tx_is_k_o", tx_is_k_o, 16'h0000);
    endtask

    task automatic event_order();
        reg_data_t rd;
        int        expected;
        write_reg(REG_PRESC, 16'd3);
        write_reg(REG_CTRL, SRC_BIT);
        repeat (40) @(posedge clk);
        #DRIVE_DELAY;
        write_reg(REG_CTRL, 16'h0000);
        expected = 0;
        read_reg(REG_EVT_DATA, rd);
        while (rd[EVT_VALID] && expected < 32)
        begin
            expect_value("EVT_DATA", rd, VALID_BIT | reg_data_t'(expected));
            expected++;
            read_reg(REG_EVT_DATA, rd);
        end
        expect_value("EVT_DATA", rd, 16'h0000);
        expect_true(expected >= 9, "event source produced fewer than 9 events");
    endtask

    task automatic back_pressure();
        reg_data_t rd;
        int        polls;
        write_reg(REG_CTRL, CLEAR_BIT);  // Source counter and code back to 0
        write_reg(REG_PRESC, 16'd0);
        write_reg(REG_CTRL, SRC_BIT);
        polls = 0;
        read_reg(REG_STATUS, rd);
        while (!rd[STAT_FULL] && polls < 64)
        begin
            polls++;
            read_reg(REG_STATUS, rd);
        end
        expect_true(rd[STAT_FULL], "FIFO never reported full with the source running");
        expect_value("STATUS", rd, status_word(EVT_FIFO_DEPTH));
        // Source refills behind each pop
        for (int i = 0; i < 48; i++)
        begin
            read_reg(REG_EVT_DATA, rd);
            expect_value("EVT_DATA", rd, VALID_BIT | reg_data_t'(i));
        end
        write_reg(REG_CTRL, CLEAR_BIT);
        verify_reg(REG_STATUS, status_word(0), "STATUS");
        write_reg(REG_CTRL, SRC_BIT);
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        write_reg(REG_CTRL, 16'h0000);
        for (int i = 0; i < 3; i++)
        begin
            verify_reg(REG_EVT_DATA, VALID_BIT | reg_data_t'(i), "EVT_DATA");
        end
    endtask

    initial
    begin
        seed        = 32'h15c26dfd;
        errors      = 0;
        checks      = 0;
        reg_addr_i  = '0;
        reg_wr_i    = 1'b0;
        reg_rd_i    = 1'b0;
        reg_wdata_i = '0;
        @(negedge reset_i);
        check_after_reset();
        readback_regs();
        frame_pattern();
        event_order();
        back_pressure();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

// ==== flist.f ====
logic/evt_link_pkg.sv
logic/evt_regmap_pkg.sv
logic/evt_ifs.sv
logic/evt_regs.sv
logic/evt_source.sv
logic/evt_fifo.sv
logic/frame_gen.sv
logic/evt_link_top.sv
dv/tb_clkgen.sv
dv/evt_link_properties.sv
dv/evt_link_tb.sv

// ==== Makefile ====
TOP = evt_link_tb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir

# An aborted run also counts as a failure
run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "Simulation failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; else echo "PASS"; fi

clean:
	rm -rf obj_dir $(LOG)
